/* vlog.f */
+incdir+testbench
source/spi_pkg.sv
source/spi_engine.sv
source/spi_port.sv
source/spi_io_bus.sv
source/spi_top.sv
testbench/tb_spi_top.sv

/* Makefile */
# Verilator build and run of the SPI subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := FAIL: see errors above

SRCS := $(wildcard source/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_spi_tasks.svh */
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// --------------------------------------------------
// address helpers
// --------------------------------------------------
function automatic io_addr_t reg_addr(input io_addr_t base, input reg_off_t off);
  return base + io_addr_t'(off);
endfunction

function automatic spi_dq_t port_oe(input io_addr_t base);
  return (base == PORT_BASE_FLASH) ? flash_pad.oe : eve_pad.oe;
endfunction

// --------------------------------------------------
// host bus
// --------------------------------------------------
task automatic bus_write(input io_addr_t adr, input io_data_t dat);
  @(posedge pclk);
  io_req <= '{wr: 1'b1, rd: 1'b0, addr: adr, wdata: dat};
  @(posedge pclk);   // strobe sampled at this edge
  io_req <= '0;
endtask

task automatic bus_read(input io_addr_t adr, output io_data_t dat);
  @(posedge pclk);
  io_req <= '{wr: 1'b0, rd: 1'b1, addr: adr, wdata: '0};
  @(negedge pclk);   // read mux settled mid cycle
  dat = io_rdata;
endtask

// counts the busy cycles from the edge that took the start
task automatic wait_idle(input string name, input io_addr_t base, output int low_cycles);
  io_req <= '{wr: 1'b0, rd: 1'b1, addr: reg_addr(base, REG_IDLE), wdata: '0};
  low_cycles = 0;
  oe_seen    = '0;
  @(negedge pclk);
  while (io_rdata[0] == 1'b0 && low_cycles < IDLE_WAIT_MAX) begin
    low_cycles++;
    oe_seen = oe_seen | port_oe(base);
    @(negedge pclk);
  end
  check_true(name, low_cycles < IDLE_WAIT_MAX, "port did not return to idle in time");
endtask

// --------------------------------------------------
// checks
// --------------------------------------------------
task automatic check_value(input string name, input io_data_t exp, input io_data_t act);
  checks++;
  assert (act === exp) else begin
    $display("ERROR %s: expected %h, actual %h", name, exp, act);
    errors++;
  end
endtask

task automatic check_true(input string name, input logic cond, input string what);
  checks++;
  assert (cond) else begin
    $display("%s: %s", name, what);
    errors++;
  end
endtask

task automatic end_test(input string name);
  int    fails;
  string verdict;
  fails         = errors - test_err_base;
  test_err_base = errors;
  tests++;
  if (fails == 0)
    verdict = "ok";
  else
    verdict = "FAILED";
  $display("%-18s %s, %0d errors", name, verdict, fails);
endtask

`endif

/* testbench/tb_spi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_top
  import spi_pkg::*;
();

  localparam int MAX_CYCLES    = 600;  // tests need about 150 cycles
  localparam int IDLE_WAIT_MAX = 64;   // twice the longest transfer

  logic     pclk;
  logic     SCKclock;
  io_req_t  io_req;
  io_data_t io_rdata;
  pad_t     eve_pad;
  pad_t     flash_pad;
  spi_dq_t  eve_dq;
  spi_dq_t  flash_dq;
  spi_dq_t  eve_ext = '0;   // external quad device on the eve port
  spi_dq_t  flash_ext;

  int errors;
  int checks;
  int tests;
  int test_err_base;
  int cycles;
  int seed = 31593;

  logic       feed_on;
  logic [1:0] nib_idx = '0;
  spi_dq_t    nibs [4];
  spi_dq_t    oe_seen;       // OR of enables over one transfer

  io_data_t   rd;
  io_data_t   tx;
  io_data_t   eve_rx_before;
  int         low;
  io_addr_t   unmapped [6];

  `include "tb_spi_tasks.svh"

  spi_top uut (
    .pclk        (pclk),
    .SCKclock    (SCKclock),
    .io_req_i    (io_req),
    .io_rdata_o  (io_rdata),
    .eve_pad_o   (eve_pad),
    .eve_dq_i    (eve_dq),
    .flash_pad_o (flash_pad),
    .flash_dq_i  (flash_dq)
  );

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  // --------------------------------------------------
  // pad model
  // --------------------------------------------------

  // driven lines read back their own level and undriven ones see the device
  function automatic spi_dq_t pad_loopback(input pad_t pad, input spi_dq_t ext);
    spi_dq_t dq;
    dq = (pad.out.dq & pad.oe) | (ext & ~pad.oe);
    if (!pad.oe[1] && pad.oe[0])
      dq[1] = pad.out.dq[0];   // MOSI wired back into MISO
    return dq;
  endfunction

  assign eve_dq   = pad_loopback(eve_pad, eve_ext);
  assign flash_dq = pad_loopback(flash_pad, flash_ext);

  // device presents the next nibble after each SCK-high cycle
  always @(posedge pclk) begin
    if (!feed_on) begin
      nib_idx <= '0;
      eve_ext <= nibs[0];
    end else if (eve_pad.out.sck && nib_idx != 2'd3) begin
      nib_idx <= nib_idx + 2'd1;
      eve_ext <= nibs[nib_idx + 2'd1];
    end
  end

  task automatic arm_feed();
    @(posedge pclk);
    feed_on <= 1'b0;
    @(posedge pclk);   // feed rewinds to nibble 0 here
    feed_on <= 1'b1;
  endtask

  always @(posedge pclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    SCKclock  = 1'b1;
    io_req    = '0;
    feed_on   = 1'b0;
    flash_ext = '0;
    for (int i = 0; i < 4; i++)
      nibs[i] = '0;
    // offsets 1..3 outside the windows would alias rx or idle
    unmapped = '{12'h003, 12'h0FA, 12'h104, 12'h109, 12'h11B, 12'hFFF};
    repeat (3) @(posedge pclk);
    SCKclock <= 1'b0;

    bus_read(reg_addr(PORT_BASE_EVE, REG_IDLE), rd);
    check_value("reset_state", 16'h0001, rd);
    bus_read(reg_addr(PORT_BASE_FLASH, REG_IDLE), rd);
    check_value("reset_state", 16'h0001, rd);
    bus_read(reg_addr(PORT_BASE_EVE, REG_START8), rd);
    check_value("reset_state", 16'h0000, rd);
    bus_read(reg_addr(PORT_BASE_FLASH, REG_START16), rd);
    check_value("reset_state", 16'h0000, rd);
    check_value("reset_state", 16'h0000, {10'h000, eve_pad.out});
    check_value("reset_state", 16'h0000, {10'h000, flash_pad.out});
    check_value("reset_state", 16'h000D, {12'h000, eve_pad.oe});
    check_value("reset_state", 16'h000D, {12'h000, flash_pad.oe});
    end_test("reset_state");

    // CS=1 SCK=1 dq=0101 stays invisible until the strobe is sampled
    @(posedge pclk);
    io_req <= '{wr: 1'b1, rd: 1'b0, addr: reg_addr(PORT_BASE_EVE, REG_PINS), wdata: 16'h0035};
    @(negedge pclk);
    check_value("manual_pins", 16'h0000, {10'h000, eve_pad.out});
    @(posedge pclk);
    io_req <= '0;
    @(negedge pclk);
    check_value("manual_pins", 16'h0035, {10'h000, eve_pad.out});
    bus_read(reg_addr(PORT_BASE_EVE, REG_PINS), rd);
    check_value("manual_pins", 16'h0007, rd);   // IO1 follows IO0
    bus_write(reg_addr(PORT_BASE_FLASH, REG_PINS), 16'h0023);
    @(negedge pclk);
    check_value("manual_pins", 16'h0023, {10'h000, flash_pad.out});
    bus_read(reg_addr(PORT_BASE_FLASH, REG_PINS), rd);
    check_value("manual_pins", 16'h0003, rd);
    bus_write(reg_addr(PORT_BASE_EVE, REG_PINS), 16'h0000);
    bus_write(reg_addr(PORT_BASE_FLASH, REG_PINS), 16'h0000);
    end_test("manual_pins");

    tx = 16'($random(seed));
    bus_write(reg_addr(PORT_BASE_EVE, REG_START8), tx);
    wait_idle("single_byte", PORT_BASE_EVE, low);
    check_value("single_byte", 16'd16, 16'(low));
    check_value("single_byte", 16'h000D, {12'h000, oe_seen});
    bus_read(reg_addr(PORT_BASE_EVE, REG_START8), rd);
    check_value("single_byte", {8'h00, tx[7:0]}, {8'h00, rd[7:0]});
    end_test("single_byte");

    tx = 16'($random(seed));
    bus_write(reg_addr(PORT_BASE_EVE, REG_START16), tx);
    wait_idle("single_word", PORT_BASE_EVE, low);
    check_value("single_word", 16'd32, 16'(low));
    bus_read(reg_addr(PORT_BASE_EVE, REG_START16), rd);
    check_value("single_word", {tx[7:0], tx[15:8]}, rd);
    end_test("single_word");

    // quad input with dir=1 takes its nibbles from the device
    bus_write(reg_addr(PORT_BASE_EVE, REG_DIR), 16'h0001);
    bus_write(reg_addr(PORT_BASE_EVE, REG_QUAD), 16'h0001);
    for (int i = 0; i < 4; i++)
      nibs[i] = 4'($random(seed));
    arm_feed();
    bus_write(reg_addr(PORT_BASE_EVE, REG_START16), 16'($random(seed)));
    wait_idle("quad_word", PORT_BASE_EVE, low);
    check_value("quad_word", 16'd8, 16'(low));
    check_value("quad_word", 16'h0000, {12'h000, oe_seen});
    bus_read(reg_addr(PORT_BASE_EVE, REG_START16), rd);
    check_value("quad_word", {nibs[0], nibs[1], nibs[2], nibs[3]}, rd);
    end_test("quad_word");

    for (int i = 0; i < 4; i++)
      nibs[i] = 4'($random(seed));
    arm_feed();
    bus_write(reg_addr(PORT_BASE_EVE, REG_START8), 16'($random(seed)));
    wait_idle("quad_byte", PORT_BASE_EVE, low);
    check_value("quad_byte", 16'd4, 16'(low));
    check_value("quad_byte", 16'h0000, {12'h000, oe_seen});
    bus_read(reg_addr(PORT_BASE_EVE, REG_START8), rd);
    check_value("quad_byte", {8'h00, nibs[0], nibs[1]}, {8'h00, rd[7:0]});
    bus_write(reg_addr(PORT_BASE_EVE, REG_DIR), 16'h0000);
    bus_write(reg_addr(PORT_BASE_EVE, REG_QUAD), 16'h0000);
    feed_on <= 1'b0;
    end_test("quad_byte");

    bus_read(reg_addr(PORT_BASE_EVE, REG_START8), eve_rx_before);
    tx = 16'($random(seed));
    bus_write(reg_addr(PORT_BASE_FLASH, REG_START16), tx);
    io_req <= '{wr: 1'b0, rd: 1'b1, addr: reg_addr(PORT_BASE_EVE, REG_IDLE), wdata: '0};
    @(negedge pclk);
    check_value("port_independence", 16'h0001, io_rdata);   // flash busy here
    @(posedge pclk);
    wait_idle("port_independence", PORT_BASE_FLASH, low);
    check_true("port_independence", low > 0, "flash port never went busy");
    bus_read(reg_addr(PORT_BASE_FLASH, REG_START16), rd);
    check_value("port_independence", {tx[7:0], tx[15:8]}, rd);
    bus_read(reg_addr(PORT_BASE_EVE, REG_START8), rd);
    check_value("port_independence", eve_rx_before, rd);
    bus_read(reg_addr(PORT_BASE_EVE, REG_IDLE), rd);
    check_value("port_independence", 16'h0001, rd);
    end_test("port_independence");

    foreach (unmapped[i]) begin
      bus_read(unmapped[i], rd);
      check_value("address_map", 16'h0000, rd);
    end
    end_test("address_map");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/spi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_top
  import spi_pkg::*;
(
  input  var logic    pclk,
  input  var logic    SCKclock,
  input  var io_req_t io_req_i,
  output io_data_t    io_rdata_o,
  output pad_t        eve_pad_o,
  input  var spi_dq_t eve_dq_i,
  output pad_t        flash_pad_o,
  input  var spi_dq_t flash_dq_i
);

  port_ctl_t  eve_ctl;
  port_ctl_t  flash_ctl;
  port_stat_t eve_stat;
  port_stat_t flash_stat;

  // --------------------------------------------------
  // host bus decode
  // --------------------------------------------------
  spi_io_bus u_bus (
    .io_req_i     (io_req_i),
    .eve_ctl_o    (eve_ctl),
    .flash_ctl_o  (flash_ctl),
    .eve_stat_i   (eve_stat),
    .flash_stat_i (flash_stat),
    .io_rdata_o   (io_rdata_o)
  );

  // --------------------------------------------------
  // ports
  // --------------------------------------------------

  // eve graphics controller, base 0x100
  spi_port u_eve (
    .pclk     (pclk),
    .SCKclock (SCKclock),
    .ctl_i    (eve_ctl),
    .stat_o   (eve_stat),
    .pad_o    (eve_pad_o),
    .dq_i     (eve_dq_i)
  );

  // config flash, base 0x110
  spi_port u_flash (
    .pclk     (pclk),
    .SCKclock (SCKclock),
    .ctl_i    (flash_ctl),
    .stat_o   (flash_stat),
    .pad_o    (flash_pad_o),
    .dq_i     (flash_dq_i)
  );

endmodule

`default_nettype wire

/* source/spi_io_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_io_bus
  import spi_pkg::*;
(
  input  var io_req_t    io_req_i,
  output port_ctl_t      eve_ctl_o,
  output port_ctl_t      flash_ctl_o,
  input  var port_stat_t eve_stat_i,
  input  var port_stat_t flash_stat_i,
  output io_data_t       io_rdata_o
);

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // one port window: base must be aligned to the window size
  function automatic port_ctl_t decode_port(input io_req_t req, input io_addr_t base);
    port_ctl_t ctl;
    logic      hit;
    logic      wr_hit;
    reg_off_t  off;
    off    = req.addr[REG_OFF_W-1:0];
    hit    = (req.addr[IO_ADDR_W-1:REG_OFF_W] == base[IO_ADDR_W-1:REG_OFF_W]);
    wr_hit = req.wr & hit;

    ctl.wr_pins = wr_hit & (off == REG_PINS);
    ctl.start8  = wr_hit & (off == REG_START8);
    ctl.start16 = wr_hit & (off == REG_START16);
    ctl.wr_dir  = wr_hit & (off == REG_DIR);
    ctl.wr_quad = wr_hit & (off == REG_QUAD);
    ctl.rd_sel  = hit;
    ctl.off     = off;
    ctl.wdata   = req.wdata;
    return ctl;
  endfunction

  // read value of one port, zero when not addressed
  function automatic io_data_t read_port(input port_ctl_t ctl, input port_stat_t stat);
    io_data_t rdata;
    rdata = '0;
    if (ctl.rd_sel) begin
      case (ctl.off)
        REG_PINS:    rdata = {{(IO_DATA_W-SPI_DQ_W){1'b0}}, stat.dq};
        REG_START8,
        REG_START16: rdata = stat.rx;
        REG_IDLE:    rdata = {{(IO_DATA_W-1){1'b0}}, stat.idle};
        default:     rdata = '0;   // dir/quad are write only
      endcase
    end
    return rdata;
  endfunction

  // --------------------------------------------------
  // per-port arrays
  // --------------------------------------------------
  io_addr_t   port_base [NUM_PORTS];
  port_ctl_t  port_ctl  [NUM_PORTS];
  port_stat_t port_stat [NUM_PORTS];

  assign port_base[0] = PORT_BASE_EVE;
  assign port_base[1] = PORT_BASE_FLASH;

  assign port_stat[0] = eve_stat_i;
  assign port_stat[1] = flash_stat_i;

  // write strobes stay combinational, a start is seen at the same edge
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      port_ctl[p] = decode_port(io_req_i, port_base[p]);
    end
  end

  assign eve_ctl_o   = port_ctl[0];
  assign flash_ctl_o = port_ctl[1];

  // --------------------------------------------------
  // read data
  // --------------------------------------------------

  // windows never overlap, so OR-ing is a plain mux
  always_comb begin
    io_rdata_o = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      io_rdata_o = io_rdata_o | read_port(port_ctl[p], port_stat[p]);
    end
  end

endmodule

`default_nettype wire

/* source/spi_port.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_port
  import spi_pkg::*;
(
  input  var logic       pclk,
  input  var logic       SCKclock,
  input  var port_ctl_t  ctl_i,
  output port_stat_t     stat_o,
  output pad_t           pad_o,
  input  var spi_dq_t    dq_i
);

  spi_pins_t man_pins_q;   // software-driven pin levels
  logic      dir_q;        // 1 = quad lines are inputs
  logic      quad_q;

  io_data_t  eng_rx;
  logic      eng_idle;
  spi_pins_t eng_pins;
  spi_dq_t   eng_mask;

  // --------------------------------------------------
  // control registers
  // --------------------------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      man_pins_q <= '0;
      dir_q      <= 1'b0;
      quad_q     <= 1'b0;
    end else begin
      if (ctl_i.wr_pins)
        man_pins_q <= ctl_i.wdata[$bits(spi_pins_t)-1:0];
      if (ctl_i.wr_dir)
        dir_q <= ctl_i.wdata[0];
      if (ctl_i.wr_quad)
        quad_q <= ctl_i.wdata[0];
    end
  end

  // --------------------------------------------------
  // shift engine
  // --------------------------------------------------
  spi_engine u_engine (
    .pclk      (pclk),
    .SCKclock  (SCKclock),
    .start8_i  (ctl_i.start8),
    .start16_i (ctl_i.start16),
    .tx_i      (ctl_i.wdata),
    .dir_i     (dir_q),
    .quad_i    (quad_q),
    .dq_i      (dq_i),
    .rx_o      (eng_rx),
    .idle_o    (eng_idle),
    .pins_o    (eng_pins),
    .mask_o    (eng_mask)
  );

  // --------------------------------------------------
  // pads
  // --------------------------------------------------

  // manual levels and engine levels merge, so software can hold CS
  // while the engine clocks data
  assign pad_o.out.cs  = man_pins_q.cs  | eng_pins.cs;
  assign pad_o.out.sck = man_pins_q.sck | eng_pins.sck;
  assign pad_o.out.dq  = man_pins_q.dq  | eng_pins.dq;

  assign pad_o.oe = ~eng_mask;   // mask marks the input lines

  assign stat_o.rx   = eng_rx;
  assign stat_o.idle = eng_idle;
  assign stat_o.dq   = dq_i;     // raw pad levels for the pins read

endmodule

`default_nettype wire

/* source/spi_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_engine
  import spi_pkg::*;
(
  input  var logic     pclk,
  input  var logic     SCKclock,
  input  var logic     start8_i,
  input  var logic     start16_i,
  input  var io_data_t tx_i,
  input  var logic     dir_i,
  input  var logic     quad_i,
  input  var spi_dq_t  dq_i,
  output io_data_t     rx_o,
  output logic         idle_o,
  output spi_pins_t    pins_o,
  output spi_dq_t      mask_o
);

  logic     running_q;
  spi_cnt_t counter_q;
  io_data_t shifter_q;

  spi_cnt_t counter_n;
  io_data_t tx_swap;
  logic     sck;

  // byte transfers start at mid range and run half as long
  assign counter_n = counter_q + (quad_i ? CNT_STEP_QUAD : CNT_STEP_SINGLE);

  // low byte goes out first
  assign tx_swap = {tx_i[7:0], tx_i[15:8]};

  // counter bit 0 toggles every cycle, bit 2 every step of 4
  assign sck = quad_i ? counter_q[2] : counter_q[0];

  // --------------------------------------------------
  // counter and shifter
  // --------------------------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      running_q <= 1'b0;
      counter_q <= '0;
      shifter_q <= '0;
    end else if (start8_i) begin
      running_q <= 1'b1;
      counter_q <= CNT_BYTE_LOAD;
      shifter_q <= tx_swap;
    end else if (start16_i) begin
      running_q <= 1'b1;
      counter_q <= CNT_WORD_LOAD;
      shifter_q <= tx_swap;
    end else if (running_q) begin
      running_q <= (counter_n != '0);   // done on wrap
      counter_q <= counter_n;
      if (sck) begin
        if (quad_i)
          shifter_q <= {shifter_q[IO_DATA_W-SPI_DQ_W-1:0], dq_i};
        else
          shifter_q <= {shifter_q[IO_DATA_W-2:0], dq_i[1]};   // MISO is IO1
      end
    end
  end

  assign rx_o   = shifter_q;
  assign idle_o = ~running_q;

  // --------------------------------------------------
  // pins
  // --------------------------------------------------
  assign pins_o.cs  = 1'b0;   // CS is left to the manual register
  assign pins_o.sck = sck;
  assign pins_o.dq  = quad_i ? shifter_q[IO_DATA_W-1 -: SPI_DQ_W]
                             : {3'b000, shifter_q[IO_DATA_W-1]};

  // quad: dir picks all-in or all-out; single: only IO1 listens
  assign mask_o = quad_i ? {SPI_DQ_W{dir_i}} : 4'b0010;

endmodule

`default_nettype wire

/* source/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int IO_ADDR_W = 12;
  localparam int IO_DATA_W = 16;
  localparam int SPI_CNT_W = 5;
  localparam int SPI_DQ_W  = 4;
  localparam int REG_OFF_W = 3;   // offset bits inside one port window

  localparam int NUM_PORTS = 2;

  typedef logic [IO_ADDR_W-1:0] io_addr_t;
  typedef logic [IO_DATA_W-1:0] io_data_t;
  typedef logic [SPI_CNT_W-1:0] spi_cnt_t;
  typedef logic [SPI_DQ_W-1:0]  spi_dq_t;    // IO3..IO0
  typedef logic [REG_OFF_W-1:0] reg_off_t;

  // --------------------------------------------------
  // address map
  // --------------------------------------------------
  localparam io_addr_t PORT_BASE_EVE   = 12'h100;
  localparam io_addr_t PORT_BASE_FLASH = 12'h110;

  localparam reg_off_t REG_PINS    = 3'd0;  // manual pins / pad inputs
  localparam reg_off_t REG_START8  = 3'd1;  // byte start / rx
  localparam reg_off_t REG_START16 = 3'd2;  // word start / rx
  localparam reg_off_t REG_IDLE    = 3'd3;
  localparam reg_off_t REG_DIR     = 3'd4;
  localparam reg_off_t REG_QUAD    = 3'd5;

  // engine counter: a byte runs the top half of the count range
  localparam spi_cnt_t CNT_BYTE_LOAD   = 5'd16;
  localparam spi_cnt_t CNT_WORD_LOAD   = 5'd0;
  localparam spi_cnt_t CNT_STEP_SINGLE = 5'd1;
  localparam spi_cnt_t CNT_STEP_QUAD   = 5'd4;

  typedef struct packed {
    logic     wr;
    logic     rd;
    io_addr_t addr;
    io_data_t wdata;
  } io_req_t;

  // same bit order as the board: CS SCK IO3 IO2 IO1 IO0
  typedef struct packed {
    logic    cs;
    logic    sck;
    spi_dq_t dq;
  } spi_pins_t;

  typedef struct packed {
    logic     wr_pins;
    logic     start8;
    logic     start16;
    logic     wr_dir;
    logic     wr_quad;
    logic     rd_sel;   // this port's window is addressed
    reg_off_t off;
    io_data_t wdata;
  } port_ctl_t;

  typedef struct packed {
    io_data_t rx;
    logic     idle;
    spi_dq_t  dq;
  } port_stat_t;

  typedef struct packed {
    spi_pins_t out;
    spi_dq_t   oe;      // 1 = line driven
  } pad_t;

endpackage

`default_nettype wire
